// File: vlog.f
logic/prog_pkg.sv
logic/inst_mem.sv
logic/inst_decode.sv
logic/alu_execute.sv
logic/result_port.sv
logic/prog_engine.sv
test/prog_engine_tb.sv

// File: Makefile
TOP = prog_engine_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module prog_engine_tb -f vlog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module prog_engine_tb \
		-Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/prog_engine_tb.sv
`timescale 1ns/1ps

module prog_engine_tb;

    //////////////////////////////////////////////////////////////////////
    // Run parameters
    //////////////////////////////////////////////////////////////////////

    localparam int          IM_ADDR_WIDTH = 5;
    localparam int          DEPTH         = 2 ** IM_ADDR_WIDTH;
    localparam int          NUM_RANDOM    = 40;
    // Random programs then the full load and the overfull load
    localparam int          NUM_PROGRAMS  = NUM_RANDOM + 2;
    localparam int          CYCLE_LIMIT   = NUM_PROGRAMS * (DEPTH + DEPTH + 16) + 100;
    localparam int unsigned SEED          = 32'hf5268aab;
    // Fetch, decode, execute, result register
    localparam int          PIPE_LAT      = 4;

    logic                                  clk;
    logic                                  rst;
    logic                                  inst_v;
    logic [prog_pkg::INST_WIDTH-1:0]       inst_in;
    logic                                  result_v;
    logic [prog_pkg::DATA_WIDTH-1:0]       result_data;
    logic [prog_pkg::RESULT_IDX_WIDTH-1:0] result_idx;
    logic                                  done;
    logic [prog_pkg::RESULT_IDX_WIDTH-1:0] out_count;
    logic                                  busy;

    // Program being loaded and its expected results
    logic [prog_pkg::INST_WIDTH-1:0]       prog_words [DEPTH + 8];
    logic [prog_pkg::DATA_WIDTH-1:0]       exp_data_q [$];
    logic [prog_pkg::RESULT_IDX_WIDTH-1:0] exp_idx_q  [$];
    // Program address of each OUT
    int                                    exp_addr_q [$];
    logic [prog_pkg::RESULT_IDX_WIDTH-1:0] exp_count;
    // Words that actually replay
    int                                    n_exec;

    // Cycle bookkeeping
    int cyc;
    int load_end_cyc;
    int loaded_cnt;
    int done_cnt     = 0;

    // Totals
    int errors       = 0;
    int results_seen = 0;
    int programs_run;

    prog_engine #(
        .IM_ADDR_WIDTH (IM_ADDR_WIDTH)
    ) i_prog_engine (
        .clk         (clk),
        .rst         (rst),
        .inst_v      (inst_v),
        .inst_in     (inst_in),
        .result_v    (result_v),
        .result_data (result_data),
        .result_idx  (result_idx),
        .done        (done),
        .out_count   (out_count),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog counting rising edges for the whole run
    initial begin
        cyc = 0;
        while (cyc < CYCLE_LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Summary: %0d errors, %0d programs, %0d results checked",
                 errors, programs_run, results_seen);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Error reporting
    //////////////////////////////////////////////////////////////////////

    task automatic flag_mismatch(input string sig, input logic [31:0] expv,
                                 input logic [31:0] actv);
        errors++;
        $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, sig, expv, actv);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    // Random words with OUT and LDI favoured so values show up
    task automatic make_program(input int n);
        logic [3:0] opc;
        int         sel;
        for (int i = 0; i < n; i++) begin
            sel = int'($urandom % 10);
            if (sel < 3) begin
                opc = prog_pkg::OP_OUT;
            end else if (sel < 5) begin
                opc = prog_pkg::OP_LDI;
            end else begin
                // Full 4-bit range, unused codes too
                opc = 4'($urandom % 16);
            end
            prog_words[i] = {opc, 12'($urandom)};
        end
    endtask

    // Register file model zeroed for every program
    task automatic build_expected(input int n);
        logic [7:0] regs [4];
        logic [3:0] opc;
        logic [1:0] dst;
        logic [1:0] src;
        logic [7:0] imm;
        for (int r = 0; r < 4; r++) begin
            regs[r] = '0;
        end
        exp_data_q.delete();
        exp_idx_q.delete();
        exp_addr_q.delete();
        exp_count = '0;
        for (int k = 0; k < n; k++) begin
            // opcode 15:12, dst 11:10, src 9:8, imm 7:0
            {opc, dst, src, imm} = prog_words[k];
            case (opc)
                prog_pkg::OP_LDI: regs[dst] = imm;
                // 8-bit arithmetic wraps by itself
                prog_pkg::OP_ADD: regs[dst] = regs[dst] + regs[src];
                prog_pkg::OP_SUB: regs[dst] = regs[dst] - regs[src];
                prog_pkg::OP_AND: regs[dst] = regs[dst] & regs[src];
                prog_pkg::OP_OR:  regs[dst] = regs[dst] | regs[src];
                prog_pkg::OP_XOR: regs[dst] = regs[dst] ^ regs[src];
                prog_pkg::OP_SHL: regs[dst] = regs[dst] << imm[2:0];
                prog_pkg::OP_OUT: begin
                    exp_data_q.push_back(regs[src]);
                    exp_idx_q.push_back(exp_count);
                    exp_addr_q.push_back(k);
                    exp_count++;
                end
                // NOP and unused codes change nothing
                default: ;
            endcase
        end
    endtask

    // One word per cycle and then inst_v low
    task automatic stream_program(input int n_load);
        for (int i = 0; i < n_load; i++) begin
            inst_v  = 1'b1;
            inst_in = prog_words[i];
            @(posedge clk);
            #1;
        end
        inst_v  = 1'b0;
        inst_in = '0;
        // Next edge sees inst_v low and ends the load
        load_end_cyc = cyc + 1;
        loaded_cnt++;
    endtask

    task automatic run_program(input int n_load);
        int seen;
        // Words past the memory end never replay
        n_exec = (n_load > DEPTH) ? DEPTH : n_load;
        build_expected(n_exec);
        seen = done_cnt;
        stream_program(n_load);
        // Watchdog bounds this wait
        while (done_cnt == seen) begin
            @(posedge clk);
        end
        programs_run++;
        repeat ($urandom % 3) @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor sampled on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        logic       armed;
        logic       exp_busy;
        logic [7:0] exp_d;
        logic [7:0] exp_i;
        int         exp_a;
        armed    = loaded_cnt > done_cnt;
        // busy spans first execute result up to the done edge
        exp_busy = armed && (cyc >= load_end_cyc + PIPE_LAT)
                   && (cyc < load_end_cyc + n_exec + PIPE_LAT);
        assert (busy === exp_busy)
            else flag_mismatch("busy", 32'(exp_busy), 32'(busy));

        if (result_v !== 1'b0) begin
            assert (exp_data_q.size() != 0)
                else report_failure("unexpected result: result_v high with no OUT pending");
            if (exp_data_q.size() != 0) begin
                exp_d = exp_data_q.pop_front();
                exp_i = exp_idx_q.pop_front();
                exp_a = exp_addr_q.pop_front();
                results_seen++;
                assert (result_data === exp_d)
                    else flag_mismatch("result_data", 32'(exp_d), 32'(result_data));
                assert (result_idx === exp_i)
                    else flag_mismatch("result_idx", 32'(exp_i), 32'(result_idx));
                // OUT at address k lands k+4 cycles after load end
                assert (cyc == load_end_cyc + PIPE_LAT + exp_a)
                    else flag_mismatch("result_v cycle", 32'(load_end_cyc + PIPE_LAT + exp_a),
                                       32'(cyc));
            end
        end

        if (done !== 1'b0) begin
            assert (armed)
                else report_failure("done pulsed with no program in replay");
            if (armed) begin
                assert (cyc == load_end_cyc + n_exec + PIPE_LAT)
                    else flag_mismatch("done cycle", 32'(load_end_cyc + n_exec + PIPE_LAT),
                                       32'(cyc));
                assert (out_count === exp_count)
                    else flag_mismatch("out_count", 32'(exp_count), 32'(out_count));
                assert (exp_data_q.size() == 0)
                    else report_failure("done arrived before every expected result");
                done_cnt++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst === 1'b0) begin
            check_outputs();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int len;
        rst          = 1'b1;
        inst_v       = 1'b0;
        inst_in      = '0;
        loaded_cnt   = 0;
        load_end_cyc = 0;
        n_exec       = 0;
        exp_count    = '0;
        programs_run = 0;
        void'($urandom(SEED));

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // Quiet stretch before any load
        repeat (4) @(posedge clk);
        #1;

        // Back to back random programs
        for (int p = 0; p < NUM_RANDOM; p++) begin
            len = 1 + int'($urandom % DEPTH);
            make_program(len);
            run_program(len);
        end

        // Memory filled exactly
        make_program(DEPTH);
        run_program(DEPTH);

        // Last three words fall off the end
        make_program(DEPTH + 3);
        run_program(DEPTH + 3);

        // Room for a stray strobe after the last done
        repeat (10) @(posedge clk);

        $display("Summary: %0d errors, %0d programs, %0d results checked",
                 errors, programs_run, results_seen);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: logic/prog_engine.sv
`timescale 1ns/1ps

module prog_engine #(
    parameter int IM_ADDR_WIDTH = 5
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  inst_v,
    input  logic [prog_pkg::INST_WIDTH-1:0]       inst_in,
    output logic                                  result_v,
    output logic [prog_pkg::DATA_WIDTH-1:0]       result_data,
    output logic [prog_pkg::RESULT_IDX_WIDTH-1:0] result_idx,
    output logic                                  done,
    output logic [prog_pkg::RESULT_IDX_WIDTH-1:0] out_count,
    output logic                                  busy
);

    //////////////////////////////////////////////////////////////////////
    // Stage to stage wiring
    //////////////////////////////////////////////////////////////////////

    // Fetch
    logic                               fetch_v;
    logic [prog_pkg::INST_WIDTH-1:0]    fetch_inst;
    logic                               fetch_last;
    logic                               start;

    // Decode
    logic                               dec_v;
    prog_pkg::alu_op_e                  dec_op;
    logic [prog_pkg::REG_IDX_WIDTH-1:0] dec_dst;
    logic [prog_pkg::REG_IDX_WIDTH-1:0] dec_src;
    logic [prog_pkg::DATA_WIDTH-1:0]    dec_imm;
    logic                               dec_last;
    logic                               dec_start;

    // Execute
    logic                               out_v;
    logic [prog_pkg::DATA_WIDTH-1:0]    out_data;
    logic                               end_v;
    logic                               begin_v;

    // Program store and replay counter
    inst_mem #(
        .IM_ADDR_WIDTH (IM_ADDR_WIDTH)
    ) i_inst_mem (
        .clk        (clk),
        .rst        (rst),
        .inst_v     (inst_v),
        .inst_in    (inst_in),
        .fetch_v    (fetch_v),
        .fetch_inst (fetch_inst),
        .fetch_last (fetch_last),
        .start      (start)
    );

    inst_decode i_inst_decode (
        .clk        (clk),
        .rst        (rst),
        .fetch_v    (fetch_v),
        .fetch_inst (fetch_inst),
        .fetch_last (fetch_last),
        .start      (start),
        .dec_v      (dec_v),
        .dec_op     (dec_op),
        .dec_dst    (dec_dst),
        .dec_src    (dec_src),
        .dec_imm    (dec_imm),
        .dec_last   (dec_last),
        .dec_start  (dec_start)
    );

    alu_execute i_alu_execute (
        .clk        (clk),
        .rst        (rst),
        .dec_v      (dec_v),
        .dec_op     (dec_op),
        .dec_dst    (dec_dst),
        .dec_src    (dec_src),
        .dec_imm    (dec_imm),
        .dec_last   (dec_last),
        .dec_start  (dec_start),
        .out_v      (out_v),
        .out_data   (out_data),
        .end_v      (end_v),
        .begin_v    (begin_v)
    );

    // Numbered results and end of program
    result_port i_result_port (
        .clk         (clk),
        .rst         (rst),
        .out_v       (out_v),
        .out_data    (out_data),
        .end_v       (end_v),
        .begin_v     (begin_v),
        .result_v    (result_v),
        .result_data (result_data),
        .result_idx  (result_idx),
        .done        (done),
        .out_count   (out_count),
        .busy        (busy)
    );

endmodule

// File: logic/result_port.sv
`timescale 1ns/1ps

module result_port (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  out_v,
    input  logic [prog_pkg::DATA_WIDTH-1:0]       out_data,
    input  logic                                  end_v,
    input  logic                                  begin_v,
    output logic                                  result_v,
    output logic [prog_pkg::DATA_WIDTH-1:0]       result_data,
    output logic [prog_pkg::RESULT_IDX_WIDTH-1:0] result_idx,
    output logic                                  done,
    output logic [prog_pkg::RESULT_IDX_WIDTH-1:0] out_count,
    output logic                                  busy
);

    // OUTs seen so far in this program
    logic [prog_pkg::RESULT_IDX_WIDTH-1:0] out_cnt;
    // Index for the current OUT, restarted with the program
    logic [prog_pkg::RESULT_IDX_WIDTH-1:0] idx_base;

    // begin_v can share a cycle with the first OUT
    assign idx_base = begin_v ? '0 : out_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_cnt   <= '0;
            result_v  <= 1'b0;
            done      <= 1'b0;
            out_count <= '0;
            busy      <= 1'b0;
        end else begin
            result_v <= out_v;
            done     <= end_v;
            out_cnt  <= out_v ? idx_base + 1'b1 : idx_base;
            // Final count is settled by the end strobe
            if (end_v) begin
                out_count <= out_cnt;
            end
            // busy falls on the same edge done rises
            if (begin_v) begin
                busy <= 1'b1;
            end else if (end_v) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        result_data <= out_data;
        result_idx  <= idx_base;
    end

endmodule

// File: logic/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               dec_v,
    input  prog_pkg::alu_op_e                  dec_op,
    input  logic [prog_pkg::REG_IDX_WIDTH-1:0] dec_dst,
    input  logic [prog_pkg::REG_IDX_WIDTH-1:0] dec_src,
    input  logic [prog_pkg::DATA_WIDTH-1:0]    dec_imm,
    input  logic                               dec_last,
    input  logic                               dec_start,
    output logic                               out_v,
    output logic [prog_pkg::DATA_WIDTH-1:0]    out_data,
    output logic                               end_v,
    output logic                               begin_v
);

    // Register file
    logic [prog_pkg::DATA_WIDTH-1:0] regs     [prog_pkg::REG_COUNT];
    // Register view seen by this instruction
    logic [prog_pkg::DATA_WIDTH-1:0] cur_regs [prog_pkg::REG_COUNT];
    logic [prog_pkg::DATA_WIDTH-1:0] dst_val;
    logic [prog_pkg::DATA_WIDTH-1:0] src_val;
    logic [prog_pkg::DATA_WIDTH-1:0] alu_res;
    logic                            wr_en;
    logic                            prog_clear;
    // Last instruction has gone through execute
    logic                            last_q;

    //////////////////////////////////////////////////////////////////////
    // Operand read and ALU
    //////////////////////////////////////////////////////////////////////

    // Start of program sees an all zero register file
    assign prog_clear = dec_v & dec_start;

    always_comb begin
        for (int i = 0; i < prog_pkg::REG_COUNT; i++) begin
            cur_regs[i] = prog_clear ? '0 : regs[i];
        end
    end

    assign dst_val = cur_regs[dec_dst];
    assign src_val = cur_regs[dec_src];

    always_comb begin
        alu_res = dst_val;
        wr_en   = 1'b1;
        case (dec_op)
            prog_pkg::ALU_LDI: alu_res = dec_imm;
            // Wraps modulo 256
            prog_pkg::ALU_ADD: alu_res = dst_val + src_val;
            prog_pkg::ALU_SUB: alu_res = dst_val - src_val;
            prog_pkg::ALU_AND: alu_res = dst_val & src_val;
            prog_pkg::ALU_OR:  alu_res = dst_val | src_val;
            prog_pkg::ALU_XOR: alu_res = dst_val ^ src_val;
            // Shift amount is the low three imm bits
            prog_pkg::ALU_SHL: alu_res = dst_val << dec_imm[2:0];
            default:           wr_en   = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register write and output strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < prog_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            out_v   <= 1'b0;
            last_q  <= 1'b0;
            end_v   <= 1'b0;
            begin_v <= 1'b0;
        end else begin
            out_v   <= dec_v & (dec_op == prog_pkg::ALU_OUT);
            last_q  <= dec_v & dec_last;
            // One cycle behind the last OUT strobe
            end_v   <= last_q;
            begin_v <= prog_clear;
            if (dec_v) begin
                // Commit the cleared view on program start
                for (int i = 0; i < prog_pkg::REG_COUNT; i++) begin
                    regs[i] <= cur_regs[i];
                end
                if (wr_en) begin
                    regs[dec_dst] <= alu_res;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        out_data <= src_val;
    end

endmodule

// File: logic/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  fetch_v,
    input  logic [prog_pkg::INST_WIDTH-1:0]       fetch_inst,
    input  logic                                  fetch_last,
    input  logic                                  start,
    output logic                                  dec_v,
    output prog_pkg::alu_op_e                     dec_op,
    output logic [prog_pkg::REG_IDX_WIDTH-1:0]    dec_dst,
    output logic [prog_pkg::REG_IDX_WIDTH-1:0]    dec_src,
    output logic [prog_pkg::DATA_WIDTH-1:0]       dec_imm,
    output logic                                  dec_last,
    output logic                                  dec_start
);

    logic [prog_pkg::OP_WIDTH-1:0] opcode;
    prog_pkg::alu_op_e             op_next;
    // LDI and SHL carry an immediate
    logic                          imm_used;

    assign opcode = fetch_inst[prog_pkg::OPC_MSB:prog_pkg::OPC_LSB];

    //////////////////////////////////////////////////////////////////////
    // Opcode mapping
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        op_next  = prog_pkg::ALU_NOP;
        imm_used = 1'b0;
        case (opcode)
            prog_pkg::OP_NOP: op_next = prog_pkg::ALU_NOP;
            prog_pkg::OP_LDI: begin
                op_next  = prog_pkg::ALU_LDI;
                imm_used = 1'b1;
            end
            prog_pkg::OP_ADD: op_next = prog_pkg::ALU_ADD;
            prog_pkg::OP_SUB: op_next = prog_pkg::ALU_SUB;
            prog_pkg::OP_AND: op_next = prog_pkg::ALU_AND;
            prog_pkg::OP_OR:  op_next = prog_pkg::ALU_OR;
            prog_pkg::OP_XOR: op_next = prog_pkg::ALU_XOR;
            prog_pkg::OP_SHL: begin
                op_next  = prog_pkg::ALU_SHL;
                imm_used = 1'b1;
            end
            // Register to emit is in the src field
            prog_pkg::OP_OUT: op_next = prog_pkg::ALU_OUT;
            // Unused opcodes fall through as nop
            default:          op_next = prog_pkg::ALU_NOP;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Decode register stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_v     <= 1'b0;
            dec_last  <= 1'b0;
            dec_start <= 1'b0;
        end else begin
            dec_v     <= fetch_v;
            dec_last  <= fetch_v & fetch_last;
            dec_start <= fetch_v & start;
        end
    end

    // Decoded instruction fields
    always_ff @(posedge clk) begin
        dec_op  <= op_next;
        dec_dst <= fetch_inst[prog_pkg::DST_MSB:prog_pkg::DST_LSB];
        dec_src <= fetch_inst[prog_pkg::SRC_MSB:prog_pkg::SRC_LSB];
        dec_imm <= imm_used ? fetch_inst[prog_pkg::IMM_MSB:prog_pkg::IMM_LSB] : '0;
    end

endmodule

// File: logic/inst_mem.sv
`timescale 1ns/1ps

module inst_mem #(
    parameter int IM_ADDR_WIDTH = 5
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inst_v,
    input  logic [prog_pkg::INST_WIDTH-1:0] inst_in,
    output logic                            fetch_v,
    output logic [prog_pkg::INST_WIDTH-1:0] fetch_inst,
    output logic                            fetch_last,
    output logic                            start
);

    localparam int DEPTH = 2 ** IM_ADDR_WIDTH;

    // Program storage
    logic [prog_pkg::INST_WIDTH-1:0] mem [DEPTH];

    // Load side
    logic [IM_ADDR_WIDTH-1:0] load_addr;
    logic [IM_ADDR_WIDTH:0]   word_cnt;
    logic                     inst_v_q;
    logic                     mem_full;
    logic                     wr_en;
    logic                     load_end;

    // Replay side
    logic [IM_ADDR_WIDTH-1:0] pc;
    logic [IM_ADDR_WIDTH:0]   last_addr;
    logic                     pc_at_end;
    logic                     replaying;

    // Shared port address
    logic [IM_ADDR_WIDTH-1:0] mem_addr;

    //////////////////////////////////////////////////////////////////////
    // Load and replay control decode
    //////////////////////////////////////////////////////////////////////

    // Count one wider than the address so a full memory is visible
    assign mem_full  = word_cnt == (IM_ADDR_WIDTH + 1)'(DEPTH);
    // Extra words past the end are dropped
    assign wr_en     = inst_v & ~replaying & ~mem_full;
    // First low cycle after a load burst
    assign load_end  = inst_v_q & ~inst_v & ~replaying & (word_cnt != '0);
    assign last_addr = word_cnt - 1'b1;
    assign pc_at_end = {1'b0, pc} == last_addr;
    // Read by pc during replay, else write by load address
    assign mem_addr  = replaying ? pc : load_addr;

    //////////////////////////////////////////////////////////////////////
    // Memory array
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[mem_addr] <= inst_in;
        end
        // One cycle read latency
        fetch_inst <= mem[mem_addr];
    end

    //////////////////////////////////////////////////////////////////////
    // Counters and fetch strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_v_q   <= 1'b0;
            load_addr  <= '0;
            word_cnt   <= '0;
            pc         <= '0;
            replaying  <= 1'b0;
            fetch_v    <= 1'b0;
            fetch_last <= 1'b0;
            start      <= 1'b0;
        end else begin
            // Host level is ignored while replaying
            inst_v_q   <= inst_v & ~replaying;
            // Strobes line up with the word read this cycle
            fetch_v    <= replaying;
            fetch_last <= replaying & pc_at_end;
            start      <= replaying & (pc == '0);

            if (wr_en) begin
                load_addr <= load_addr + 1'b1;
                word_cnt  <= word_cnt + 1'b1;
            end

            if (load_end) begin
                replaying <= 1'b1;
                pc        <= '0;
            end else if (replaying) begin
                pc <= pc + 1'b1;
                if (pc_at_end) begin
                    // Back to idle with a clean load state
                    replaying <= 1'b0;
                    pc        <= '0;
                    load_addr <= '0;
                    word_cnt  <= '0;
                end
            end
        end
    end

endmodule

// File: logic/prog_pkg.sv
package prog_pkg;

    //////////////////////////////////////////////////////////////////////
    // Word and datapath widths
    //////////////////////////////////////////////////////////////////////

    localparam int INST_WIDTH       = 16;
    localparam int DATA_WIDTH       = 8;
    localparam int REG_COUNT        = 4;
    localparam int REG_IDX_WIDTH    = $clog2(REG_COUNT);
    localparam int OP_WIDTH         = 4;
    // Result index and OUT count on the result port
    localparam int RESULT_IDX_WIDTH = 8;

    // Instruction field layout
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int DST_MSB = 11;
    localparam int DST_LSB = 10;
    localparam int SRC_MSB = 9;
    localparam int SRC_LSB = 8;
    localparam int IMM_MSB = 7;
    localparam int IMM_LSB = 0;

    //////////////////////////////////////////////////////////////////////
    // Opcodes as stored in memory
    //////////////////////////////////////////////////////////////////////

    localparam logic [OP_WIDTH-1:0] OP_NOP = 4'h0;
    localparam logic [OP_WIDTH-1:0] OP_LDI = 4'h1;
    localparam logic [OP_WIDTH-1:0] OP_ADD = 4'h2;
    localparam logic [OP_WIDTH-1:0] OP_SUB = 4'h3;
    localparam logic [OP_WIDTH-1:0] OP_AND = 4'h4;
    localparam logic [OP_WIDTH-1:0] OP_OR  = 4'h5;
    localparam logic [OP_WIDTH-1:0] OP_XOR = 4'h6;
    localparam logic [OP_WIDTH-1:0] OP_SHL = 4'h7;
    localparam logic [OP_WIDTH-1:0] OP_OUT = 4'h8;

    // Execute operations after decode
    // Nine operations so the code needs four bits
    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_LDI = 4'd1,
        ALU_ADD = 4'd2,
        ALU_SUB = 4'd3,
        ALU_AND = 4'd4,
        ALU_OR  = 4'd5,
        ALU_XOR = 4'd6,
        ALU_SHL = 4'd7,
        ALU_OUT = 4'd8
    } alu_op_e;

endpackage
